/* hdl/mips_isa_pkg.sv */
package mips_isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [2:0]  alu_sel_t;
	typedef logic [7:0]  alu_op_t;
	typedef logic [4:0]  exc_code_t;

	localparam int DMEM_WORDS = 64;
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);
	typedef logic [DMEM_AW-1:0] dmem_addr_t;

	localparam alu_sel_t SEL_NOP       = 3'b000;	// Bubbles carry this class
	localparam alu_sel_t SEL_LOGIC     = 3'b001;
	localparam alu_sel_t SEL_SHIFT     = 3'b010;
	localparam alu_sel_t SEL_MOVE      = 3'b011;
	localparam alu_sel_t SEL_ARITH     = 3'b100;
	localparam alu_sel_t SEL_MUL       = 3'b101;
	localparam alu_sel_t SEL_LOADSTORE = 3'b111;

	localparam alu_op_t OP_SLL   = 8'b0000_0000;	// SPECIAL funct codes
	localparam alu_op_t OP_SRL   = 8'b0000_0010;
	localparam alu_op_t OP_SRA   = 8'b0000_0011;
	localparam alu_op_t OP_MFHI  = 8'b0001_0000;
	localparam alu_op_t OP_MTHI  = 8'b0001_0001;
	localparam alu_op_t OP_MFLO  = 8'b0001_0010;
	localparam alu_op_t OP_MTLO  = 8'b0001_0011;
	localparam alu_op_t OP_MULT  = 8'b0001_1000;
	localparam alu_op_t OP_MULTU = 8'b0001_1001;
	localparam alu_op_t OP_ADD   = 8'b0010_0000;
	localparam alu_op_t OP_ADDU  = 8'b0010_0001;
	localparam alu_op_t OP_SUB   = 8'b0010_0010;
	localparam alu_op_t OP_SUBU  = 8'b0010_0011;
	localparam alu_op_t OP_AND   = 8'b0010_0100;
	localparam alu_op_t OP_OR    = 8'b0010_0101;
	localparam alu_op_t OP_XOR   = 8'b0010_0110;
	localparam alu_op_t OP_NOR   = 8'b0010_0111;
	localparam alu_op_t OP_SLT   = 8'b0010_1010;
	localparam alu_op_t OP_SLTU  = 8'b0010_1011;
	localparam alu_op_t OP_LUI   = 8'b0000_1111;	// Opcode of lui
	localparam alu_op_t OP_LB    = 8'b1110_0000;	// Loads and stores use the opcode with the top bits set
	localparam alu_op_t OP_LW    = 8'b1110_0011;
	localparam alu_op_t OP_LBU   = 8'b1110_0100;
	localparam alu_op_t OP_SB    = 8'b1110_1000;
	localparam alu_op_t OP_SW    = 8'b1110_1011;

	localparam exc_code_t EXC_NONE = 5'd0;
	localparam exc_code_t EXC_ADEL = 5'd4;	// Address error on load
	localparam exc_code_t EXC_ADES = 5'd5;	// Address error on store

endpackage

/* hdl/pipe_pkg.sv */
package pipe_pkg;

	typedef logic [5:0] stall_t;

	// Stall vector positions, 0 is fetch and 1 is decode
	localparam int STALL_EX  = 3;
	localparam int STALL_MEM = 4;	// Holds EX/MEM
	localparam int STALL_WB  = 5;

	typedef struct packed {
		mips_isa_pkg::alu_sel_t  alu_sel;
		mips_isa_pkg::alu_op_t   alu_op;
		mips_isa_pkg::word_t     reg1;
		mips_isa_pkg::word_t     reg2;
		mips_isa_pkg::word_t     imm;
		mips_isa_pkg::reg_addr_t waddr;
		logic                    we;
		mips_isa_pkg::word_t     inst_addr;
	} id_ex_t;

	typedef struct packed {
		logic                    we;
		mips_isa_pkg::reg_addr_t waddr;
		mips_isa_pkg::word_t     wdata;
		logic                    whilo;
		mips_isa_pkg::word_t     hi;
		mips_isa_pkg::word_t     lo;
		mips_isa_pkg::alu_sel_t  alu_sel;
		mips_isa_pkg::alu_op_t   alu_op;
		mips_isa_pkg::word_t     ram_addr;
		mips_isa_pkg::word_t     reg2;	// Store data
		mips_isa_pkg::exc_code_t exc;
		mips_isa_pkg::word_t     inst_addr;
	} ex_mem_t;

	typedef struct packed {
		logic                    we;
		mips_isa_pkg::reg_addr_t waddr;
		mips_isa_pkg::word_t     wdata;
		logic                    whilo;
		mips_isa_pkg::word_t     hi;
		mips_isa_pkg::word_t     lo;
	} mem_wb_t;

	typedef struct packed {
		logic                    valid;
		mips_isa_pkg::exc_code_t code;
		mips_isa_pkg::word_t     epc;
	} exc_report_t;

endpackage

/* hdl/ex_stage.sv */
`timescale 1ns/100ps

module ex_stage (
	input  logic                clk,
	input  logic                reset_n,
	input  pipe_pkg::id_ex_t    id_ex,
	input  logic                flush,
	input  pipe_pkg::ex_mem_t   fwd_mem,
	input  pipe_pkg::mem_wb_t   fwd_wb,
	input  mips_isa_pkg::word_t hi,
	input  mips_isa_pkg::word_t lo,
	output pipe_pkg::ex_mem_t   ex_out,
	output logic                stall_req_ex
);

	mips_isa_pkg::word_t hi_fwd;
	mips_isa_pkg::word_t lo_fwd;
	mips_isa_pkg::word_t logic_res;
	mips_isa_pkg::word_t shift_res;
	mips_isa_pkg::word_t arith_res;
	mips_isa_pkg::word_t move_res;
	mips_isa_pkg::word_t ram_addr;
	logic                is_mul;
	logic                is_mthi;
	logic                is_mtlo;
	logic                mul_phase;
	logic [63:0]         prod_s;
	logic [63:0]         prod_u;
	logic [63:0]         prod;

	// Youngest HI/LO writer wins
	assign hi_fwd = fwd_mem.whilo ? fwd_mem.hi : (fwd_wb.whilo ? fwd_wb.hi : hi);
	assign lo_fwd = fwd_mem.whilo ? fwd_mem.lo : (fwd_wb.whilo ? fwd_wb.lo : lo);

	always_comb begin
		case (id_ex.alu_op)
			mips_isa_pkg::OP_AND: logic_res = id_ex.reg1 & id_ex.reg2;
			mips_isa_pkg::OP_OR:  logic_res = id_ex.reg1 | id_ex.reg2;
			mips_isa_pkg::OP_XOR: logic_res = id_ex.reg1 ^ id_ex.reg2;
			mips_isa_pkg::OP_NOR: logic_res = ~(id_ex.reg1 | id_ex.reg2);
			mips_isa_pkg::OP_LUI: logic_res = {id_ex.imm[15:0], 16'h0000};
			default:              logic_res = '0;
		endcase
	end

	always_comb begin	// reg1 carries the shift amount, reg2 the value
		case (id_ex.alu_op)
			mips_isa_pkg::OP_SLL: shift_res = id_ex.reg2 << id_ex.reg1[4:0];
			mips_isa_pkg::OP_SRL: shift_res = id_ex.reg2 >> id_ex.reg1[4:0];
			mips_isa_pkg::OP_SRA: shift_res = $signed(id_ex.reg2) >>> id_ex.reg1[4:0];
			default:              shift_res = '0;
		endcase
	end

	always_comb begin
		case (id_ex.alu_op)
			mips_isa_pkg::OP_ADD, mips_isa_pkg::OP_ADDU: arith_res = id_ex.reg1 + id_ex.reg2;
			mips_isa_pkg::OP_SUB, mips_isa_pkg::OP_SUBU: arith_res = id_ex.reg1 - id_ex.reg2;
			mips_isa_pkg::OP_SLT:  arith_res = {31'd0, $signed(id_ex.reg1) < $signed(id_ex.reg2)};
			mips_isa_pkg::OP_SLTU: arith_res = {31'd0, id_ex.reg1 < id_ex.reg2};
			default:               arith_res = '0;
		endcase
	end

	always_comb begin
		case (id_ex.alu_op)
			mips_isa_pkg::OP_MFHI: move_res = hi_fwd;
			mips_isa_pkg::OP_MFLO: move_res = lo_fwd;
			default:               move_res = '0;
		endcase
	end

	assign ram_addr = id_ex.reg1 + {{16{id_ex.imm[15]}}, id_ex.imm[15:0]};
	assign is_mul   = (id_ex.alu_sel == mips_isa_pkg::SEL_MUL);
	assign is_mthi  = (id_ex.alu_sel == mips_isa_pkg::SEL_MOVE) &&
		(id_ex.alu_op == mips_isa_pkg::OP_MTHI);
	assign is_mtlo  = (id_ex.alu_sel == mips_isa_pkg::SEL_MOVE) &&
		(id_ex.alu_op == mips_isa_pkg::OP_MTLO);

	// Both operands signed, so they are sign-extended to 64 bits first
	assign prod_s = $signed(id_ex.reg1) * $signed(id_ex.reg2);
	assign prod_u = {32'd0, id_ex.reg1} * {32'd0, id_ex.reg2};

	assign stall_req_ex = is_mul & ~mul_phase;	// First multiply cycle holds the front end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			mul_phase <= 1'b0;
		end else if (flush) begin
			mul_phase <= 1'b0;
		end else begin
			mul_phase <= stall_req_ex;	// Set for the cycle that passes the product on
		end
	end

	always_ff @(posedge clk) begin
		if (stall_req_ex) begin
			prod <= (id_ex.alu_op == mips_isa_pkg::OP_MULT) ? prod_s : prod_u;
		end
	end

	always_comb begin
		ex_out           = '0;
		ex_out.we        = id_ex.we;
		ex_out.waddr     = id_ex.waddr;
		ex_out.alu_sel   = id_ex.alu_sel;
		ex_out.alu_op    = id_ex.alu_op;
		ex_out.ram_addr  = ram_addr;
		ex_out.reg2      = id_ex.reg2;
		ex_out.inst_addr = id_ex.inst_addr;
		case (id_ex.alu_sel)
			mips_isa_pkg::SEL_LOGIC: ex_out.wdata = logic_res;
			mips_isa_pkg::SEL_SHIFT: ex_out.wdata = shift_res;
			mips_isa_pkg::SEL_ARITH: ex_out.wdata = arith_res;
			mips_isa_pkg::SEL_MOVE:  ex_out.wdata = move_res;
			default:                 ex_out.wdata = '0;
		endcase
		ex_out.whilo = is_mul | is_mthi | is_mtlo;
		ex_out.hi    = is_mul ? prod[63:32] : (is_mthi ? id_ex.reg1 : hi_fwd);	// Keep the other half
		ex_out.lo    = is_mul ? prod[31:0] : (is_mtlo ? id_ex.reg1 : lo_fwd);
		ex_out.exc   = mips_isa_pkg::EXC_NONE;
		if (id_ex.alu_sel == mips_isa_pkg::SEL_LOADSTORE && ram_addr[1:0] != 2'b00) begin
			if (id_ex.alu_op == mips_isa_pkg::OP_LW)
				ex_out.exc = mips_isa_pkg::EXC_ADEL;
			else if (id_ex.alu_op == mips_isa_pkg::OP_SW)
				ex_out.exc = mips_isa_pkg::EXC_ADES;
		end
	end

endmodule

/* hdl/ex_mem.sv */
`timescale 1ns/100ps

module ex_mem (
	input  logic              clk,
	input  logic              reset_n,
	input  pipe_pkg::stall_t  stall,
	input  logic              flush,
	input  pipe_pkg::ex_mem_t ex_out,
	output pipe_pkg::ex_mem_t mem_in
);

	pipe_pkg::ex_mem_t bubble;

	// Payload rides along, only the fields that cause side effects are killed
	always_comb begin
		bubble         = ex_out;
		bubble.we      = 1'b0;
		bubble.whilo   = 1'b0;
		bubble.exc     = mips_isa_pkg::EXC_NONE;
		bubble.alu_sel = mips_isa_pkg::SEL_NOP;
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			mem_in <= '0;
		end else if (flush) begin
			mem_in <= '0;	// Younger than the faulting access
		end else if (!stall[pipe_pkg::STALL_MEM]) begin
			if (stall[pipe_pkg::STALL_EX]) begin
				mem_in <= bubble;	// Execute is busy, memory moves on
			end else begin
				mem_in <= ex_out;
			end
		end
	end

endmodule

/* hdl/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage (
	input  logic                  clk,
	input  logic                  reset_n,
	input  pipe_pkg::ex_mem_t     mem_in,
	output pipe_pkg::mem_wb_t     mem_out,
	output pipe_pkg::exc_report_t exc_raw
);

	mips_isa_pkg::word_t      dmem [mips_isa_pkg::DMEM_WORDS];
	mips_isa_pkg::dmem_addr_t word_idx;
	logic [1:0]               lane;
	logic                     fault;
	logic                     is_load;
	logic                     is_store;
	logic [3:0]               byte_en;
	mips_isa_pkg::word_t      store_data;
	mips_isa_pkg::word_t      rdata;
	mips_isa_pkg::word_t      load_data;
	logic [7:0]               load_byte;

	assign word_idx = mem_in.ram_addr[mips_isa_pkg::DMEM_AW+1:2];
	assign lane     = mem_in.ram_addr[1:0];
	assign fault    = (mem_in.exc != mips_isa_pkg::EXC_NONE);
	assign is_store = (mem_in.alu_sel == mips_isa_pkg::SEL_LOADSTORE) &&
		(mem_in.alu_op == mips_isa_pkg::OP_SB || mem_in.alu_op == mips_isa_pkg::OP_SW);
	assign is_load  = (mem_in.alu_sel == mips_isa_pkg::SEL_LOADSTORE) && !is_store;

	// Big-endian lanes, byte 0 of a word sits in bits 31:24
	always_comb begin
		byte_en    = 4'b0000;
		store_data = mem_in.reg2;
		if (is_store) begin
			if (mem_in.alu_op == mips_isa_pkg::OP_SB) begin
				byte_en    = 4'b1000 >> lane;
				store_data = {4{mem_in.reg2[7:0]}};
			end else begin
				byte_en = 4'b1111;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_n && !fault) begin	// A faulting store leaves memory alone
			for (int i = 0; i < 4; i++) begin
				if (byte_en[i])
					dmem[word_idx][8*i +: 8] <= store_data[8*i +: 8];
			end
		end
	end

	assign rdata     = dmem[word_idx];
	assign load_byte = rdata[(3 - lane) * 8 +: 8];

	always_comb begin
		case (mem_in.alu_op)
			mips_isa_pkg::OP_LB:  load_data = {{24{load_byte[7]}}, load_byte};
			mips_isa_pkg::OP_LBU: load_data = {24'd0, load_byte};
			mips_isa_pkg::OP_LW:  load_data = rdata;
			default:              load_data = '0;
		endcase
	end

	always_comb begin
		mem_out.we    = mem_in.we & ~fault;
		mem_out.waddr = mem_in.waddr;
		mem_out.wdata = is_load ? load_data : mem_in.wdata;
		mem_out.whilo = mem_in.whilo & ~fault;
		mem_out.hi    = mem_in.hi;
		mem_out.lo    = mem_in.lo;
		exc_raw.valid = fault;
		exc_raw.code  = mem_in.exc;
		exc_raw.epc   = mem_in.inst_addr;	// Address of the faulting access itself
	end

endmodule

/* hdl/mem_wb.sv */
`timescale 1ns/100ps

module mem_wb (
	input  logic                  clk,
	input  logic                  reset_n,
	input  pipe_pkg::stall_t      stall,
	input  logic                  flush,
	input  pipe_pkg::mem_wb_t     mem_out,
	input  pipe_pkg::exc_report_t exc_raw,
	output pipe_pkg::mem_wb_t     wb,
	output pipe_pkg::exc_report_t exc,
	output mips_isa_pkg::word_t   hi,
	output mips_isa_pkg::word_t   lo
);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wb  <= '0;
			exc <= '0;
		end else if (flush) begin
			wb  <= '0;	// The faulting instruction retires as its report only
			exc <= exc_raw;
		end else if (!stall[pipe_pkg::STALL_WB]) begin
			if (stall[pipe_pkg::STALL_MEM]) begin
				wb  <= '0;
				exc <= '0;
			end else begin
				wb  <= mem_out;
				exc <= exc_raw;
			end
		end
	end

	// Architectural pair commits one cycle after writeback
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			hi <= '0;
			lo <= '0;
		end else if (wb.whilo) begin
			hi <= wb.hi;
			lo <= wb.lo;
		end
	end

endmodule

/* hdl/stall_ctrl.sv */
`timescale 1ns/100ps

module stall_ctrl (
	input  logic             stall_req_ex,
	input  logic             exc_valid,
	output pipe_pkg::stall_t stall,
	output logic             flush
);

	always_comb begin
		stall = '0;
		flush = 1'b0;
		if (exc_valid) begin
			flush = 1'b1;	// Exception wins, nothing is held
		end else if (stall_req_ex) begin
			stall[pipe_pkg::STALL_EX:0] = '1;	// Fetch through execute wait, memory drains
		end
	end

endmodule

/* hdl/mips_back_end.sv */
`timescale 1ns/100ps

module mips_back_end (
	input  logic                  clk,
	input  logic                  reset_n,
	input  pipe_pkg::id_ex_t      id_ex,
	output pipe_pkg::stall_t      stall,
	output pipe_pkg::mem_wb_t     wb,
	output pipe_pkg::exc_report_t exc
);

	pipe_pkg::ex_mem_t     ex_out;
	pipe_pkg::ex_mem_t     mem_in;
	pipe_pkg::mem_wb_t     mem_out;
	pipe_pkg::exc_report_t exc_raw;
	mips_isa_pkg::word_t   hi;
	mips_isa_pkg::word_t   lo;
	logic                  stall_req_ex;
	logic                  flush;

	ex_stage u_ex_stage (
		.clk          (clk),
		.reset_n      (reset_n),
		.id_ex        (id_ex),
		.flush        (flush),
		.fwd_mem      (mem_in),
		.fwd_wb       (wb),
		.hi           (hi),
		.lo           (lo),
		.ex_out       (ex_out),
		.stall_req_ex (stall_req_ex)
	);

	ex_mem u_ex_mem (
		.clk     (clk),
		.reset_n (reset_n),
		.stall   (stall),
		.flush   (flush),
		.ex_out  (ex_out),
		.mem_in  (mem_in)
	);

	mem_stage u_mem_stage (
		.clk     (clk),
		.reset_n (reset_n),
		.mem_in  (mem_in),
		.mem_out (mem_out),
		.exc_raw (exc_raw)
	);

	mem_wb u_mem_wb (
		.clk     (clk),
		.reset_n (reset_n),
		.stall   (stall),
		.flush   (flush),
		.mem_out (mem_out),
		.exc_raw (exc_raw),
		.wb      (wb),
		.exc     (exc),
		.hi      (hi),
		.lo      (lo)
	);

	stall_ctrl u_stall_ctrl (
		.stall_req_ex (stall_req_ex),
		.exc_valid    (exc_raw.valid),
		.stall        (stall),
		.flush        (flush)
	);

endmodule

/* verification/tb_mips_back_end.sv */
`timescale 1ns/100ps

module tb_mips_back_end;

	localparam int CLK_PERIOD = 4;
	localparam int N_RANDOM   = 40;
	localparam logic [1:0] KIND_NONE = 2'd0;
	localparam logic [1:0] KIND_REG  = 2'd1;
	localparam logic [1:0] KIND_HILO = 2'd2;
	localparam logic [1:0] KIND_EXC  = 2'd3;
	localparam mips_isa_pkg::word_t CODE_BASE = 32'h0040_0000;	// Address of the first case

	typedef logic [8*16-1:0] name_t;

	typedef struct packed {
		name_t            name;
		logic [1:0]       kind;
		pipe_pkg::id_ex_t id;
		logic [63:0]      value;	// HI in the upper word for HI/LO results
	} case_t;

	typedef struct packed {
		name_t                   name;
		logic [1:0]              kind;
		mips_isa_pkg::reg_addr_t waddr;
		logic [63:0]             value;
		mips_isa_pkg::word_t     epc;
	} expect_t;

	logic                  clk;
	logic                  reset_n;
	pipe_pkg::id_ex_t      id_ex;
	pipe_pkg::stall_t      stall;
	pipe_pkg::mem_wb_t     wb;
	pipe_pkg::exc_report_t exc;

	case_t       cases[$];
	expect_t     pending[$];	// Results in issue order
	expect_t     head;
	logic [31:0] lfsr;
	logic        loaded;
	logic        busy;
	int          errors;
	int          passes;
	int          limit_cycles;

	mips_back_end u_dut (
		.clk     (clk),
		.reset_n (reset_n),
		.id_ex   (id_ex),
		.stall   (stall),
		.wb      (wb),
		.exc     (exc)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic mips_isa_pkg::word_t rand_bits(input int n);
		mips_isa_pkg::word_t r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic read_cases;
		int                      fd;
		int                      n;
		string                   line;
		name_t                   name;
		logic [8*4-1:0]          kind;
		mips_isa_pkg::alu_sel_t  sel;
		mips_isa_pkg::alu_op_t   op;
		mips_isa_pkg::word_t     r1;
		mips_isa_pkg::word_t     r2;
		mips_isa_pkg::word_t     imm;
		mips_isa_pkg::reg_addr_t wa;
		logic                    we;
		logic [63:0]             val;
		case_t                   c;
		fd = $fopen("verification/back_end_cases.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the cases file verification/back_end_cases.txt");
			errors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %s %h",
				name, sel, op, r1, r2, imm, wa, we, kind, val);
			if (n != 10) begin
				$display("Malformed line in the cases file: %0s", line);
				errors++;
				continue;
			end
			c            = '0;
			c.name       = name;
			c.id.alu_sel = sel;
			c.id.alu_op  = op;
			c.id.reg1    = r1;
			c.id.reg2    = r2;
			c.id.imm     = imm;
			c.id.waddr   = wa;
			c.id.we      = we;
			c.value      = val;
			if (kind == "reg")
				c.kind = KIND_REG;
			else if (kind == "hilo")
				c.kind = KIND_HILO;
			else if (kind == "exc")
				c.kind = KIND_EXC;
			else if (kind == "none")
				c.kind = KIND_NONE;
			else begin
				$display("Unknown result kind in case %0s", name);
				errors++;
			end
			cases.push_back(c);
		end
		$fclose(fd);
	endtask

	task automatic add_random_cases;
		case_t               c;
		mips_isa_pkg::word_t a;
		mips_isa_pkg::word_t b;
		logic [1:0]          pick;
		name_t               nm;
		for (int k = 0; k < N_RANDOM; k++) begin
			a    = rand_bits(32);
			b    = rand_bits(32);
			pick = 2'(rand_bits(2));
			$sformat(nm, "rand_%0d", k);
			c          = '0;
			c.name     = nm;
			c.kind     = KIND_REG;
			c.id.reg1  = a;
			c.id.reg2  = b;
			c.id.we    = 1'b1;
			c.id.waddr = 5'(rand_bits(4)) + 5'd1;	// Never r0
			case (pick)
				2'd0: begin
					c.id.alu_sel = mips_isa_pkg::SEL_ARITH;
					c.id.alu_op  = mips_isa_pkg::OP_ADD;
					c.value      = {32'd0, a + b};	// No overflow trap in this back end, so add wraps
				end
				2'd1: begin
					c.id.alu_sel = mips_isa_pkg::SEL_LOGIC;
					c.id.alu_op  = mips_isa_pkg::OP_XOR;
					c.value      = {32'd0, a ^ b};
				end
				default: begin
					c.id.alu_sel = mips_isa_pkg::SEL_ARITH;
					c.id.alu_op  = mips_isa_pkg::OP_SLTU;
					c.value      = (a < b) ? 64'd1 : 64'd0;
				end
			endcase
			cases.push_back(c);
		end
	endtask

	task automatic issue_case(input int i);
		case_t   c;
		expect_t e;
		c = cases[i];
		c.id.inst_addr = CODE_BASE + 32'(i) * 32'd4;
		id_ex = c.id;
		if (c.kind == KIND_NONE) begin
			$display("--   %0s issued, no result expected", c.name);
		end else begin
			e.name  = c.name;
			e.kind  = c.kind;
			e.waddr = c.id.waddr;
			e.value = c.value;
			e.epc   = c.id.inst_addr;
			pending.push_back(e);
		end
	endtask

	task automatic check_word(input name_t name, input mips_isa_pkg::reg_addr_t exp_addr,
		input mips_isa_pkg::word_t exp_data, input mips_isa_pkg::reg_addr_t got_addr,
		input mips_isa_pkg::word_t got_data);
		if (got_addr !== exp_addr || got_data !== exp_data) begin
			$display("[ERROR] %0s: expected r%0d = %h, actual r%0d = %h",
				name, exp_addr, exp_data, got_addr, got_data);
			errors++;
		end else begin
			$display("ok   %0s: r%0d = %h", name, got_addr, got_data);
			passes++;
		end
	endtask

	task automatic check_hilo(input name_t name, input mips_isa_pkg::word_t exp_hi,
		input mips_isa_pkg::word_t exp_lo, input mips_isa_pkg::word_t got_hi,
		input mips_isa_pkg::word_t got_lo);
		if (got_hi !== exp_hi || got_lo !== exp_lo) begin
			$display("[ERROR] %0s: expected hi/lo = %h/%h, actual hi/lo = %h/%h",
				name, exp_hi, exp_lo, got_hi, got_lo);
			errors++;
		end else begin
			$display("ok   %0s: hi/lo = %h/%h", name, got_hi, got_lo);
			passes++;
		end
	endtask

	task automatic check_exc(input name_t name, input mips_isa_pkg::exc_code_t exp_code,
		input mips_isa_pkg::word_t exp_epc, input mips_isa_pkg::exc_code_t got_code,
		input mips_isa_pkg::word_t got_epc);
		if (got_code !== exp_code || got_epc !== exp_epc) begin
			$display("[ERROR] %0s: expected code %0d epc %h, actual code %0d epc %h",
				name, exp_code, exp_epc, got_code, got_epc);
			errors++;
		end else begin
			$display("ok   %0s: exception code %0d at %h", name, got_code, got_epc);
			passes++;
		end
	endtask

	task automatic check_stall(input name_t name, input pipe_pkg::stall_t exp_stall,
		input pipe_pkg::stall_t got_stall);
		if (got_stall !== exp_stall) begin
			$display("[ERROR] %0s: expected stall %b, actual stall %b",
				name, exp_stall, got_stall);
			errors++;
		end
	endtask

	// Registered outputs are stable at the falling edge with one result per rising edge
	always @(negedge clk) begin
		if (reset_n && (exc.valid || wb.we || wb.whilo)) begin
			if (pending.size() == 0) begin
				$display("A result arrived at %0t ns while none was pending", $time);
				errors++;
			end else begin
				head = pending.pop_front();
				if (exc.valid && head.kind == KIND_EXC)
					check_exc(head.name, head.value[4:0], head.epc, exc.code, exc.epc);
				else if (!exc.valid && wb.we && head.kind == KIND_REG)
					check_word(head.name, head.waddr, head.value[31:0], wb.waddr, wb.wdata);
				else if (!exc.valid && wb.whilo && head.kind == KIND_HILO)
					check_hilo(head.name, head.value[63:32], head.value[31:0], wb.hi, wb.lo);
				else begin
					$display("%0s: the pipeline delivered a different kind of result", head.name);
					errors++;
				end
			end
		end
	end

	initial begin
		int               i;
		pipe_pkg::stall_t exp_stall;
		logic             after_fault;
		name_t            cur_name;
		clk     = 1'b0;
		reset_n = 1'b0;
		id_ex   = '0;
		lfsr    = 32'h0000_9ec9;
		loaded  = 1'b0;
		busy    = 1'b0;
		errors  = 0;
		passes  = 0;
		read_cases();
		add_random_cases();
		limit_cycles = cases.size() * 20 + 100;
		loaded = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
		i = 0;
		after_fault = 1'b0;
		cur_name = '0;
		while (i < cases.size() || busy) begin
			@(negedge clk);
			exp_stall = '0;
			if (!busy) begin
				cur_name = cases[i].name;
				if (cases[i].id.alu_sel == mips_isa_pkg::SEL_MUL && !after_fault)
					exp_stall = 6'b00_1111;	// Fetch through execute hold for the first multiply cycle
				after_fault = (cases[i].kind == KIND_EXC);	// A fault in memory flushes the next one
				issue_case(i);
				i++;
			end
			#1;
			check_stall(cur_name, exp_stall, stall);
			busy = stall[2];	// Execute still owns the instruction at the next edge
		end
		@(negedge clk);
		id_ex = '0;
		while (pending.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);	// Catch a stray write-back from a killed instruction
		@(posedge clk);
		$display("%0d checks passed, %0d errors", passes, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		wait (loaded);
		#(limit_cycles * CLK_PERIOD);
		$display("Timeout after %0d cycles, %0d results never arrived", limit_cycles,
			pending.size());
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* verification/back_end_cases.txt */
# name sel op reg1 reg2 imm waddr we kind expected, all numbers in hex
# kind is reg, hilo (hi then lo), exc (code) or none for stores and killed instructions
add_wrap      4 20 7fffffff 00000001 00000000 01 1 reg  80000000
addu_wrap     4 21 ffffffff 00000002 00000000 02 1 reg  00000001
sub_neg       4 22 00000010 00000020 00000000 03 1 reg  fffffff0
subu_zero     4 23 00000000 00000001 00000000 04 1 reg  ffffffff
and_mask      1 24 f0f0f0f0 0ff00ff0 00000000 05 1 reg  00f000f0
or_mask       1 25 f0f0f0f0 0ff00ff0 00000000 06 1 reg  fff0fff0
xor_mask      1 26 f0f0f0f0 0ff00ff0 00000000 07 1 reg  ff00ff00
nor_mask      1 27 f0f0f0f0 0ff00ff0 00000000 08 1 reg  000f000f
slt_signed    4 2a ffffffff 00000001 00000000 09 1 reg  00000001
sltu_big      4 2b ffffffff 00000001 00000000 0a 1 reg  00000000
sll_4         2 00 00000004 0000f00f 00000000 0b 1 reg  000f00f0
srl_8         2 02 00000008 80000000 00000000 0c 1 reg  00800000
sra_8         2 03 00000008 80000000 00000000 0d 1 reg  ff800000
lui_1234      1 0f 00000000 00000000 00001234 0e 1 reg  12340000
sw_word       7 eb 00000010 8899aabb 00000004 00 0 none 0
lw_word       7 e3 00000010 00000000 00000004 0f 1 reg  8899aabb
sb_lane0      7 e8 00000020 00000081 00000000 00 0 none 0
sb_lane1      7 e8 00000020 0000007e 00000001 00 0 none 0
sb_lane2      7 e8 00000020 000000c3 00000002 00 0 none 0
sb_lane3      7 e8 00000020 0000003c 00000003 00 0 none 0
lb_lane0      7 e0 00000020 00000000 00000000 10 1 reg  ffffff81
lbu_lane0     7 e4 00000020 00000000 00000000 11 1 reg  00000081
lb_lane1      7 e0 00000020 00000000 00000001 12 1 reg  0000007e
lbu_lane1     7 e4 00000020 00000000 00000001 13 1 reg  0000007e
lb_lane2      7 e0 00000020 00000000 00000002 14 1 reg  ffffffc3
lbu_lane2     7 e4 00000020 00000000 00000002 15 1 reg  000000c3
lb_lane3      7 e0 00000020 00000000 00000003 16 1 reg  0000003c
lbu_lane3     7 e4 00000020 00000000 00000003 17 1 reg  0000003c
mult_neg      5 18 fffffffe 00000003 00000000 00 0 hilo fffffffffffffffa
mfhi_fwd      3 10 00000000 00000000 00000000 18 1 reg  ffffffff
mflo_fwd      3 12 00000000 00000000 00000000 19 1 reg  fffffffa
multu_max     5 19 ffffffff ffffffff 00000000 00 0 hilo fffffffe00000001
mthi_set      3 11 12345678 00000000 00000000 00 0 hilo 1234567800000001
mtlo_set      3 13 9abcdef0 00000000 00000000 00 0 hilo 123456789abcdef0
mfhi_new      3 10 00000000 00000000 00000000 1a 1 reg  12345678
mflo_new      3 12 00000000 00000000 00000000 1b 1 reg  9abcdef0
sw_misaligned 7 eb 00000010 deadbeef 00000006 00 0 exc  5
add_killed    4 20 00000001 00000001 00000000 1c 1 none 0
lw_old        7 e3 00000010 00000000 00000004 1d 1 reg  8899aabb
lw_misaligned 7 e3 00000010 00000000 00000001 1e 1 exc  4
addu_killed   4 21 00000001 00000001 00000000 1f 1 none 0

/* tb.f */
hdl/mips_isa_pkg.sv
hdl/pipe_pkg.sv
hdl/ex_stage.sv
hdl/ex_mem.sv
hdl/mem_stage.sv
hdl/mem_wb.sv
hdl/stall_ctrl.sv
hdl/mips_back_end.sv
verification/tb_mips_back_end.sv

/* run_sim.sh */
#!/bin/sh
# Build the back-end testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_mips_back_end -f tb.f -o tb_sim
./obj_dir/tb_sim | tee sim.log
if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
grep -q "Simulation PASSED" sim.log
